//--- bench/ulaRefModel.svh
`ifndef ULA_REF_MODEL_SVH
`define ULA_REF_MODEL_SVH

`include "ula_consts.svh"

////////////////////
// Model state
////////////////////
int unsigned        mSlot;       // Slot 0..23
logic [6:0]         mH;
logic [8:0]         mV;
logic               mFreq;       // 1 = 50 Hz
logic               mNewLine;    // H wrapped on the last clock
ulaVideoPkg::colorT mInk;
ulaVideoPkg::colorT mPaper;
logic [7:0]         mFetched;    // Bus latch
logic [7:0]         mHold;
logic               mIsAttr;
logic               mInvHold;
logic               mInvPix;
logic [5:0]         mShift;
logic [15:0]        mSram;
int                 mSramKind;   // 0 none, 1 screen, 2 pattern, 3 CPU

// Six pixel strobes per CPU cycle
function automatic logic pixelSlot(input int unsigned s);
  return (s % 4) == 1;
endfunction

function automatic logic [15:0] textScreenAddr(input logic [6:0] h, input logic [8:0] v);
  return 16'(`TEXT_BASE + `BYTES_PER_ROW * (v / 8) + h);
endfunction

task automatic modelReset();
  mSlot = 0;
  mH = '0;
  mV = '0;
  mFreq = 1'b0;     // Text at 60 Hz
  mNewLine = 1'b0;
  mInk = 3'd7;
  mPaper = 3'd0;
  mFetched = '0;
  mHold = '0;
  mIsAttr = 1'b0;
  mInvHold = 1'b0;
  mInvPix = 1'b0;
  mShift = '0;
  mSram = '0;
  mSramKind = 0;
endtask

// One CLK_24 rising edge, old state in, new state out
task automatic modelStep(input logic [7:0] dbIn, input logic [15:0] addrIn);
  ulaVideoPkg::videoByteU holdView;
  ulaVideoPkg::videoByteU busView;
  logic                   visible;
  logic [8:0]             lastLine;
  holdView = mHold;
  busView  = dbIn;
  visible  = (mH >= 7'd1) && (mH <= 7'd40) && (mV < 9'd224);
  lastLine = mFreq ? 9'd312 : 9'd260;
  mNewLine = 1'b0;
  if (mSlot == 2 || mSlot == 10) mFetched = dbIn;
  if (mSlot == 3) begin
    mIsAttr  = busView.attr.kind == 2'b00;
    mInvHold = busView.data.inverse;
  end
  if ((mIsAttr && mSlot == 9) || (!mIsAttr && mSlot == 12)) mHold = mFetched;  // Text only
  // Attribute registers
  if (mH >= 7'd49) begin
    mInk   = 3'd7;
    mPaper = 3'd0;
  end else if (mSlot == 17 && mIsAttr && visible) begin
    case (holdView.attr.sel)
      ulaVideoPkg::attrInk:   mInk   = holdView.attr.value;
      ulaVideoPkg::attrPaper: mPaper = holdView.attr.value;
      ulaVideoPkg::attrMode:  mFreq  = holdView.attr.value[1];
      default: ;
    endcase
  end
  if (pixelSlot(mSlot)) begin
    if (mSlot == 17) mInvPix = mInvHold;
    if (mSlot == 17 && !mIsAttr) mShift = holdView.data.code[5:0];
    else mShift = {mShift[4:0], 1'b0};
  end
  // SRAM address sources
  if (mSlot == 23) begin
    mSram = textScreenAddr(mH, mV);
    mSramKind = 1;
  end else if (mSlot == 7) begin
    mSramKind = 2;
  end else if (mSlot == 15) begin
    mSram = addrIn;
    mSramKind = 3;
  end
  if (mSlot == 15) begin
    if (mH == 7'd63) begin
      mH = '0;
      mNewLine = 1'b1;
      mV = (mV < lastLine) ? mV + 9'd1 : 9'd0;
    end else begin
      mH = mH + 7'd1;
    end
  end
  mSlot = (mSlot + 1) % 24;
endtask

`endif

//--- bench/tbUlaTop.sv
`timescale 1ns/10ps

module tbUlaTop;

  // Three 313-line frames plus eight spare lines
  localparam int TIMEOUT_CYCLES = 3 * 313 * 64 * 24 + 8 * 64 * 24;
  localparam logic [7:0] MODE_50HZ = 8'h1A;  // Mode, 50 Hz bit, text

  logic        CLK_24;
  logic        RESET_INT;
  logic        mapN;
  logic [7:0]  db;
  logic [15:0] addr;
  logic        phi2, phi2En, pixelEn;
  logic        csIoN, csRomN, csRamN;
  logic [15:0] sramAddr;
  logic        red, green, blue;
  logic        compSync, hSyncN, vSyncN, hBlank, vBlank;

  int          cycleCount;
  int          clockPeriod;   // Period number since reset release
  int          lineCount;
  int          lastFallLine;
  int          fallsAt50;
  logic        lastFallAt50;
  logic        prevVSyncN;
  logic        seenPhi2En;
  logic        modeSent;

  `include "ulaRefModel.svh"

  ulaTop ulaTop_i (
    .CLK_24(CLK_24), .RESET_INT(RESET_INT), .mapN(mapN), .db(db), .addr(addr),
    .phi2(phi2), .phi2En(phi2En), .pixelEn(pixelEn), .csIoN(csIoN), .csRomN(csRomN),
    .csRamN(csRamN), .sramAddr(sramAddr), .red(red), .green(green), .blue(blue),
    .compSync(compSync), .hSyncN(hSyncN), .vSyncN(vSyncN), .hBlank(hBlank), .vBlank(vBlank)
  );

  initial begin
    CLK_24 = 1'b0;
    forever #10 CLK_24 = ~CLK_24;
  end

  task automatic compareSignal(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
    assert (got === exp) else begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  function automatic logic [7:0] randomDataByte();
    logic [7:0] b;
    b = 8'($urandom);
    if (b[6:5] == 2'b00) b[5] = 1'b1;  // Never an attribute
    return b;
  endfunction

  ////////////////////
  // Output checks
  ////////////////////
  task automatic checkOutputs();
    logic               io;
    logic               top;
    logic               cpu;
    logic               hs;
    logic               vs;
    ulaVideoPkg::colorT color;
    io    = addr[15:8] == 8'h03;
    top   = &addr[15:14];
    cpu   = mSlot >= 16;   // Phase 3
    color = mShift[5] ? mInk : mPaper;
    if (mInvPix) color = ~color;
    compareSignal("phi2", 16'(phi2), 16'(cpu));
    compareSignal("phi2En", 16'(phi2En), 16'(mSlot == 15));
    compareSignal("pixelEn", 16'(pixelEn), 16'(pixelSlot(mSlot)));
    if (phi2En && !seenPhi2En) begin
      compareSignal("first phi2En clock", 16'(clockPeriod), 16'd16);
      seenPhi2En = 1'b1;
    end
    compareSignal("csIoN", 16'(csIoN), 16'(!(cpu && io)));
    compareSignal("csRomN", 16'(csRomN), 16'(!(cpu && top && mapN)));
    compareSignal("csRamN", 16'(csRamN),
                  16'(!(cpu && ((top && !mapN) || (!top && !io)))));
    if ((mSramKind == 1 && mSlot <= 7) || (mSramKind == 3 && mSlot >= 16)) begin
      compareSignal("sramAddr", sramAddr, mSram);
    end
    hs = !(mH >= 7'd49 && mH <= 7'd53);
    vs = mFreq ? !(mV >= 9'd258 && mV <= 9'd259) : !(mV >= 9'd241 && mV <= 9'd242);
    compareSignal("hSyncN", 16'(hSyncN), 16'(hs));
    compareSignal("vSyncN", 16'(vSyncN), 16'(vs));
    compareSignal("compSync", 16'(compSync), 16'(!(hs ^ vs)));
    compareSignal("hBlank", 16'(hBlank), 16'(!(mH >= 7'd1 && mH <= 7'd40)));
    compareSignal("vBlank", 16'(vBlank), 16'(mV >= 9'd224));
    compareSignal("rgb", 16'({blue, green, red}), 16'(color));
    // Frame length from sync to sync
    if (prevVSyncN && !vSyncN) begin
      if (mFreq && lastFallAt50) begin
        compareSignal("vSyncN period in lines", 16'(lineCount - lastFallLine), 16'd313);
      end
      if (mFreq) fallsAt50++;
      lastFallLine = lineCount;
      lastFallAt50 = mFreq;
    end
    prevVSyncN = vSyncN;
  endtask

  // New bus byte at each line start
  task automatic driveInputs();
    addr = 16'($urandom);
    mapN = 1'($urandom);
    if (mNewLine) begin
      if (lineCount < 261) begin
        db = randomDataByte();      // First frame has no attributes
      end else if (mV == 9'd100 && !modeSent) begin
        db = MODE_50HZ;
        modeSent = 1'b1;
      end else if ($urandom % 2 == 0) begin
        db = randomDataByte();
      end else begin
        db = {3'b000, 2'b10, 3'($urandom)};  // Paper
      end
    end
  endtask

  initial begin
    cycleCount = 0;
    while (cycleCount < TIMEOUT_CYCLES) begin
      @(posedge CLK_24);
      cycleCount++;
    end
    $display("Timeout: the run did not finish within %0d clocks", TIMEOUT_CYCLES);
    $display("TEST FAILED");
    $fatal(1);
  end

  initial begin
    void'($urandom(32'h9e70_a3f6));
    RESET_INT = 1'b1;
    mapN = 1'b1;
    addr = '0;
    db = randomDataByte();
    lineCount = 0;
    lastFallLine = 0;
    fallsAt50 = 0;
    lastFallAt50 = 1'b0;
    prevVSyncN = 1'b1;
    seenPhi2En = 1'b0;
    modeSent = 1'b0;
    repeat (4) @(posedge CLK_24);
    @(negedge CLK_24);
    RESET_INT = 1'b0;
    modelReset();
    clockPeriod = 1;
    checkOutputs();
    // Through a 60 Hz frame, the switch, and a full 50 Hz frame
    while (fallsAt50 < 2) begin
      @(posedge CLK_24);
      modelStep(db, addr);
      clockPeriod++;
      if (mNewLine) lineCount++;
      @(negedge CLK_24);
      checkOutputs();
      driveInputs();
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- oricUla.f
+incdir+verilog
+incdir+bench
verilog/ulaBusPkg.sv
verilog/ulaVideoPkg.sv
verilog/ulaSequencer.sv
verilog/ulaVideoTiming.sv
verilog/ulaVideoDecoder.sv
verilog/ulaVideoAddress.sv
verilog/ulaMemoryPort.sv
verilog/ulaTop.sv
bench/tbUlaTop.sv

//--- runSim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tbUlaTop -f oricUla.f -o simUla

./obj_dir/simUla > simUla.log 2>&1 || true
cat simUla.log

if grep -q "TEST FAILED" simUla.log; then
  exit 1
fi
if ! grep -q "TEST PASSED" simUla.log; then
  exit 1
fi

//--- verilog/ulaBusPkg.sv
// Sequencer and memory bus types
package ulaBusPkg;

  `include "ula_consts.svh"

  // One bit per CLK_24 cycle of a CPU cycle
  typedef logic [`SLOT_COUNT-1:0] slotRingT;

  // Bit 0 screen fetch, bit 1 pattern fetch, bit 2 CPU access
  typedef logic [2:0] phaseRingT;

  typedef logic [15:0] memAddrT;  // CPU or SRAM address

endpackage

//--- verilog/ulaMemoryPort.sv
`timescale 1ns/10ps

module ulaMemoryPort (
  input  logic                CLK_24,
  input  ulaBusPkg::slotRingT slot,
  input  logic                phi2,
  input  logic                mapN,         // Low maps RAM over ROM
  input  ulaBusPkg::memAddrT  addr,         // CPU address
  input  ulaBusPkg::memAddrT  screenAddr,
  input  ulaBusPkg::memAddrT  patternAddr,
  output ulaBusPkg::memAddrT  sramAddr,
  output logic                csIoN,
  output logic                csRomN,
  output logic                csRamN
);

  `include "ula_consts.svh"

  logic ioPage;       // 0300..03FF
  logic topQuarter;   // C000..FFFF
  logic romSel;
  logic ramSel;

  ////////////////////
  // Chip selects
  ////////////////////
  assign ioPage     = addr[15:8] == `IO_PAGE;
  assign topQuarter = &addr[15:14];

  assign romSel = topQuarter & mapN;
  assign ramSel = (topQuarter & ~mapN) |     // Shadow RAM
                  (~topQuarter & ~ioPage);   // Main RAM

  // Only valid in the CPU phase
  assign csIoN  = ~(ioPage & phi2);
  assign csRomN = ~(romSel & phi2);
  assign csRamN = ~(ramSel & phi2);

  ////////////////////
  // SRAM address mux
  ////////////////////
  always_ff @(posedge CLK_24) begin
    if (slot[`PHASE1_SLOT]) begin
      sramAddr <= screenAddr;     // Phase 1 screen byte
    end else if (slot[`PHASE2_SLOT]) begin
      sramAddr <= patternAddr;    // Phase 2 glyph or pattern
    end else if (slot[`PHASE3_SLOT]) begin
      sramAddr <= addr;           // Held through phi2 high
    end
  end

endmodule

//--- verilog/ulaSequencer.sv
`timescale 1ns/10ps

module ulaSequencer (
  input  logic               CLK_24,
  input  logic               RESET_INT,
  output ulaBusPkg::slotRingT slot,    // One-hot slot 0..23
  output logic               phi2,     // CPU clock
  output logic               phi2En    // One clock at slot 15
);

  `include "ula_consts.svh"

  ulaBusPkg::phaseRingT phase;  // One-hot phase

  ////////////////////
  // Slot and phase rings
  ////////////////////
  always_ff @(posedge CLK_24, posedge RESET_INT) begin
    if (RESET_INT) begin
      slot  <= ulaBusPkg::slotRingT'(1);  // Slot 0
      phase <= 3'b001;                    // Phase 1
    end else begin
      slot <= {slot[`SLOT_COUNT-2:0], slot[`SLOT_COUNT-1]};  // Rotate left
      // Phase moves on the last slot of each phase
      if (slot[`PHASE2_SLOT] || slot[`PHASE3_SLOT] || slot[`PHASE1_SLOT]) begin
        phase <= {phase[1:0], phase[2]};
      end
    end
  end

  // High for slots 16..23
  assign phi2   = phase[2];

  // Pulse on the clock before phi2 rises
  assign phi2En = slot[`PHASE3_SLOT];

endmodule

//--- verilog/ulaTop.sv
`timescale 1ns/10ps

module ulaTop (
  input  logic               CLK_24,
  input  logic               RESET_INT,
  input  logic               mapN,
  input  logic [7:0]         db,
  input  ulaBusPkg::memAddrT addr,
  output logic               phi2,
  output logic               phi2En,
  output logic               pixelEn,
  output logic               csIoN,
  output logic               csRomN,
  output logic               csRamN,
  output ulaBusPkg::memAddrT sramAddr,
  output logic               red,
  output logic               green,
  output logic               blue,
  output logic               compSync,
  output logic               hSyncN,
  output logic               vSyncN,
  output logic               hBlank,
  output logic               vBlank
);

  ulaBusPkg::slotRingT    slot;
  logic [6:0]             hCount;
  logic [8:0]             vCount;
  logic                   lineEnd;
  logic                   forceText;
  logic                   blankingN;
  ulaVideoPkg::videoByteU fetchedByte;
  logic                   hiresActive;
  logic                   altCharset;
  logic                   freqSel;
  ulaBusPkg::memAddrT     screenAddr;
  ulaBusPkg::memAddrT     patternAddr;

  ulaSequencer ulaSequencer_i (
    .CLK_24(CLK_24), .RESET_INT(RESET_INT), .slot(slot), .phi2(phi2), .phi2En(phi2En)
  );

  // Raster counters run at the CPU rate
  ulaVideoTiming ulaVideoTiming_i (
    .CLK_24(CLK_24), .RESET_INT(RESET_INT), .phi2En(phi2En), .freqSel(freqSel),
    .hCount(hCount), .vCount(vCount), .lineEnd(lineEnd), .forceText(forceText),
    .blankingN(blankingN), .hBlank(hBlank), .vBlank(vBlank), .hSyncN(hSyncN),
    .vSyncN(vSyncN), .compSync(compSync)
  );

  ulaVideoDecoder ulaVideoDecoder_i (
    .CLK_24(CLK_24), .RESET_INT(RESET_INT), .db(db), .slot(slot), .lineEnd(lineEnd),
    .forceText(forceText), .blankingN(blankingN), .fetchedByte(fetchedByte),
    .hiresActive(hiresActive), .altCharset(altCharset), .freqSel(freqSel),
    .pixelEn(pixelEn), .red(red), .green(green), .blue(blue)
  );

  ulaVideoAddress ulaVideoAddress_i (
    .hCount(hCount), .vCount(vCount), .fetchedByte(fetchedByte),
    .hiresActive(hiresActive), .altCharset(altCharset),
    .screenAddr(screenAddr), .patternAddr(patternAddr)
  );

  // Single SRAM shared by video and CPU
  ulaMemoryPort ulaMemoryPort_i (
    .CLK_24(CLK_24), .slot(slot), .phi2(phi2), .mapN(mapN), .addr(addr),
    .screenAddr(screenAddr), .patternAddr(patternAddr), .sramAddr(sramAddr),
    .csIoN(csIoN), .csRomN(csRomN), .csRamN(csRamN)
  );

endmodule

//--- verilog/ulaVideoAddress.sv
`timescale 1ns/10ps

module ulaVideoAddress (
  input  logic [6:0]              hCount,
  input  logic [8:0]              vCount,
  input  ulaVideoPkg::videoByteU  fetchedByte,
  input  logic                    hiresActive,
  input  logic                    altCharset,
  output ulaBusPkg::memAddrT      screenAddr,   // Phase 1
  output ulaBusPkg::memAddrT      patternAddr   // Phase 2
);

  `include "ula_consts.svh"

  logic [8:0]         row;
  ulaBusPkg::memAddrT rowOffset;
  ulaBusPkg::memAddrT screenBase;
  logic [5:0]         charsetPrefix;

  // One row per line in hires, one per 8 lines in text
  assign row = hiresActive ? vCount : {3'b000, vCount[8:3]};

  // Row times 40 as 32 + 8
  assign rowOffset  = {2'b00, row, 5'b0} + {4'b0000, row, 3'b0};
  assign screenBase = hiresActive ? `HIRES_BASE : `TEXT_BASE;
  assign screenAddr = screenBase + rowOffset + {9'b0, hCount};

  always_comb begin
    case ({hiresActive, altCharset})
      2'b11:   charsetPrefix = `CHARSET_HIRES_ALT;
      2'b10:   charsetPrefix = `CHARSET_HIRES_STD;
      2'b01:   charsetPrefix = `CHARSET_TEXT_ALT;
      default: charsetPrefix = `CHARSET_TEXT_STD;
    endcase
  end

  // 8 bytes per glyph, row within the cell from V
  assign patternAddr = {charsetPrefix, fetchedByte.data.code, vCount[2:0]};

endmodule

//--- verilog/ulaVideoDecoder.sv
`timescale 1ns/10ps

module ulaVideoDecoder (
  input  logic                  CLK_24,
  input  logic                  RESET_INT,
  input  logic [7:0]            db,
  input  ulaBusPkg::slotRingT   slot,
  input  logic                  lineEnd,
  input  logic                  forceText,
  input  logic                  blankingN,
  output ulaVideoPkg::videoByteU fetchedByte,  // Latched bus byte
  output logic                  hiresActive,
  output logic                  altCharset,
  output logic                  freqSel,
  output logic                  pixelEn,
  output logic                  red,
  output logic                  green,
  output logic                  blue
);

  ulaVideoPkg::videoByteU dbView;     // Raw bus byte, decoded in place
  ulaVideoPkg::videoByteU holdByte;   // Byte waiting for slot 17
  logic                   isAttrib;
  logic                   invHold;    // Inverse bit of the fetched byte
  logic                   invPix;     // Inverse bit of the shifted byte
  logic                   loadHold;
  logic                   hiresSel;
  logic [5:0]             shifter;
  ulaVideoPkg::colorT     inkReg;
  ulaVideoPkg::colorT     paperReg;
  ulaVideoPkg::colorT     pixColor;
  ulaVideoPkg::colorT     rgb;

  assign dbView = db;

  always_ff @(posedge CLK_24) begin
    if (slot[2] || slot[10]) fetchedByte <= db;  // Screen byte, then pattern byte
  end

  // Classify at slot 3
  always_ff @(posedge CLK_24, posedge RESET_INT) begin
    if (RESET_INT) begin
      isAttrib <= 1'b0;
      invHold  <= 1'b0;
    end else if (slot[3]) begin
      isAttrib <= dbView.attr.kind == 2'b00;
      invHold  <= dbView.data.inverse;
    end
  end

  // Attribute after its own fetch, text after the pattern fetch
  assign loadHold = (isAttrib & slot[9]) |
                    (~isAttrib & slot[12] & ~hiresActive) |
                    (~isAttrib & slot[5] & hiresActive);

  always_ff @(posedge CLK_24) begin
    if (loadHold) holdByte <= fetchedByte;
  end

  ////////////////////
  // Attribute registers
  ////////////////////
  always_ff @(posedge CLK_24, posedge RESET_INT) begin
    if (RESET_INT) begin
      inkReg     <= 3'd7;     // White ink
      paperReg   <= 3'd0;
      altCharset <= 1'b0;
      hiresSel   <= 1'b0;     // Text
      freqSel    <= 1'b0;     // 60 Hz
    end else if (lineEnd) begin
      inkReg     <= 3'd7;     // Mode survives the line end
      paperReg   <= 3'd0;
      altCharset <= 1'b0;
    end else if (slot[17] && isAttrib && blankingN) begin
      case (holdByte.attr.sel)
        ulaVideoPkg::attrInk:   inkReg     <= holdByte.attr.value;
        ulaVideoPkg::attrStyle: altCharset <= holdByte.attr.value[0];
        ulaVideoPkg::attrPaper: paperReg   <= holdByte.attr.value;
        ulaVideoPkg::attrMode: begin
          hiresSel <= holdByte.attr.value[2];
          freqSel  <= holdByte.attr.value[1];
        end
        default: ;
      endcase
    end
  end

  assign hiresActive = hiresSel & ~forceText;

  ////////////////////
  // Pixel shifter
  ////////////////////
  assign pixelEn = slot[1] | slot[5] | slot[9] | slot[13] | slot[17] | slot[21];

  always_ff @(posedge CLK_24, posedge RESET_INT) begin
    if (RESET_INT) begin
      shifter <= '0;
      invPix  <= 1'b0;
    end else if (pixelEn) begin
      if (slot[17]) invPix <= invHold;
      if (slot[17] && !isAttrib) begin
        shifter <= holdByte.data.code[5:0];     // New cell
      end else begin
        shifter <= {shifter[4:0], 1'b0};         // MSB first, attribute cell blank
      end
    end
  end

  assign pixColor = shifter[5] ? inkReg : paperReg;
  assign rgb      = invPix ? ~pixColor : pixColor;

  assign red   = rgb[0];
  assign green = rgb[1];
  assign blue  = rgb[2];

endmodule

//--- verilog/ulaVideoPkg.sv
// Video byte and attribute types
package ulaVideoPkg;

  // Register picked by an attribute byte
  typedef enum logic [1:0] {
    attrInk   = 2'd0,
    attrStyle = 2'd1,
    attrPaper = 2'd2,
    attrMode  = 2'd3
  } attrSelE;

  // Attribute view, kind is zero
  typedef struct packed {
    logic       inverse;
    logic [1:0] kind;
    attrSelE    sel;
    logic [2:0] value;
  } attrByteS;

  // Character code or hires pattern view
  typedef struct packed {
    logic       inverse;
    logic [6:0] code;     // Low 6 bits are pixels
  } dataByteS;

  // Same fetched byte, two decodings
  typedef union packed {
    attrByteS attr;
    dataByteS data;
  } videoByteU;

  typedef logic [2:0] colorT;  // {blue, green, red}

endpackage

//--- verilog/ulaVideoTiming.sv
`timescale 1ns/10ps

module ulaVideoTiming (
  input  logic       CLK_24,
  input  logic       RESET_INT,
  input  logic       phi2En,     // Once per CPU cycle
  input  logic       freqSel,    // 1 = 50 Hz
  output logic [6:0] hCount,
  output logic [8:0] vCount,
  output logic       lineEnd,
  output logic       forceText,
  output logic       blankingN,
  output logic       hBlank,
  output logic       vBlank,
  output logic       hSyncN,
  output logic       vSyncN,
  output logic       compSync
);

  `include "ula_consts.svh"

  logic       hWrap;      // Last cycle of the line
  logic [8:0] lastLine;   // Depends on frame rate
  logic       hVisible;
  logic       vSync50N;
  logic       vSync60N;

  assign hWrap    = hCount == 7'(`LINE_CYCLES - 1);
  assign lastLine = freqSel ? `LINES_50HZ_LAST : `LINES_60HZ_LAST;

  ////////////////////
  // Raster counters
  ////////////////////
  always_ff @(posedge CLK_24, posedge RESET_INT) begin
    if (RESET_INT) begin
      hCount <= '0;
      vCount <= '0;
    end else if (phi2En) begin
      hCount <= hWrap ? 7'd0 : hCount + 7'd1;
      if (hWrap) begin
        // Also catches a 50 to 60 Hz switch late in the frame
        if (vCount < lastLine) begin
          vCount <= vCount + 9'd1;
        end else begin
          vCount <= '0;
        end
      end
    end
  end

  ////////////////////
  // Sync and blanking windows
  ////////////////////
  assign hSyncN   = ~((hCount >= `HSYNC_FIRST) && (hCount <= `HSYNC_LAST));
  assign hVisible = (hCount >= `HBLANK_FIRST_VISIBLE) && (hCount <= `HBLANK_LAST_VISIBLE);
  assign hBlank   = ~hVisible;

  assign vSync50N = ~((vCount >= `VSYNC50_FIRST) && (vCount <= `VSYNC50_LAST));
  assign vSync60N = ~((vCount >= `VSYNC60_FIRST) && (vCount <= `VSYNC60_LAST));
  assign vSyncN   = freqSel ? vSync50N : vSync60N;
  assign vBlank   = vCount >= `VBLANK_FIRST;

  assign blankingN = hVisible & ~vBlank;
  assign compSync  = ~(hSyncN ^ vSyncN);    // Low while either sync is active

  assign lineEnd   = hCount >= `LINE_END_FIRST;      // Attribute reset zone
  assign forceText = vCount >= `FORCE_TEXT_FIRST;    // Status lines

endmodule

//--- verilog/ula_consts.svh
`ifndef ULA_CONSTS_SVH
`define ULA_CONSTS_SVH

////////////////////
// CPU cycle slots
////////////////////
`define SLOT_COUNT            24      // CLK_24 cycles per CPU cycle
`define PHASE1_SLOT           5'd23   // Last slot of phase 3
`define PHASE2_SLOT           5'd7    // Last slot of phase 1
`define PHASE3_SLOT           5'd15   // Last slot of phase 2, phi2 rises after it

////////////////////
// Raster geometry
////////////////////
`define LINE_CYCLES           64      // CPU cycles per line
`define LINES_50HZ_LAST       9'd312
`define LINES_60HZ_LAST       9'd260
`define HSYNC_FIRST           7'd49
`define HSYNC_LAST            7'd53
`define HBLANK_FIRST_VISIBLE  7'd1
`define HBLANK_LAST_VISIBLE   7'd40
`define LINE_END_FIRST        7'd49   // Attribute clear window
`define VSYNC50_FIRST         9'd258
`define VSYNC50_LAST          9'd259
`define VSYNC60_FIRST         9'd241
`define VSYNC60_LAST          9'd242
`define VBLANK_FIRST          9'd224
`define FORCE_TEXT_FIRST      9'd200  // Bottom rows always text

////////////////////
// Memory map
////////////////////
`define IO_PAGE               8'h03
`define TEXT_BASE             16'hBB80
`define HIRES_BASE            16'hA000
`define BYTES_PER_ROW         40
`define CHARSET_TEXT_STD      6'h2D   // B4xx
`define CHARSET_TEXT_ALT      6'h2E   // B8xx
`define CHARSET_HIRES_STD     6'h26   // 98xx
`define CHARSET_HIRES_ALT     6'h27   // 9Cxx

`endif
